//--- Makefile
# Verilator build and run of the platformer testbench

VERILATOR ?= verilator
TOP       ?= platformer_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make test   build with Verilator, run the testbench, check the log"
	@echo "  make clean  remove the build folder and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Everything OK" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+include
design/game_pkg.sv
design/level_table.sv
design/level_sequencer.sv
design/character_motion.sv
design/scene_renderer.sv
design/platformer_top.sv
tests/platformer_tb.sv

//--- design/character_motion.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

module character_motion (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     up,
    input  wire                     left,
    input  wire                     right,
    input  wire game_pkg::level_t   level,
    input  wire                     step,
    input  wire                     respawn,
    input  wire  [`COORD_W-1:0]     door_depth,
    input  wire  [`COORD_W-1:0]     pit_a_start,
    input  wire  [`COORD_W-1:0]     pit_a_end,
    input  wire  [`COORD_W-1:0]     pit_b_start,
    input  wire  [`COORD_W-1:0]     pit_b_end,
    input  wire                     pit_b_used,
    output logic [`COORD_W-1:0]     char_x,
    output logic [`COORD_W-1:0]     char_y,
    output game_pkg::motion_t       motion
);
    import game_pkg::*;

    localparam int SPEED_W = 4;

    logic signed [SPEED_W-1:0] speed;
    logic [`COORD_W-1:0] haz_a_lo;
    logic [`COORD_W-1:0] haz_a_hi;
    logic [`COORD_W-1:0] haz_b_lo;
    logic [`COORD_W-1:0] haz_b_hi;
    logic [`COORD_W-1:0] x_right;
    logic [`COORD_W-1:0] x_left;
    logic [`COORD_W-1:0] dy;
    logic [`COORD_W-1:0] jump_dy;
    logic haz_here;
    logic haz_right;
    logic haz_left;
    logic below_floor;
    logic step_right;
    logic step_left;
    logic spawn;

    function automatic logic in_span(
        input logic [`COORD_W-1:0] x,
        input logic [`COORD_W-1:0] lo,
        input logic [`COORD_W-1:0] hi
    );
        return (x > lo) && (x < hi);
    endfunction

    ////////////////////////////////////////////////////
    // hazard intervals and walking
    ////////////////////////////////////////////////////

    assign haz_a_lo = pit_a_start + `HIT_START_TRIM;
    assign haz_a_hi = pit_a_end - `HIT_END_TRIM;
    assign haz_b_lo = pit_b_start + `HIT_START_TRIM;
    assign haz_b_hi = pit_b_end - `HIT_END_TRIM;

    assign x_right = char_x + `WALK_STEP;
    assign x_left  = char_x - `WALK_STEP;

    assign haz_here  = in_span(char_x, haz_a_lo, haz_a_hi)
                    || (pit_b_used && in_span(char_x, haz_b_lo, haz_b_hi));
    assign haz_right = in_span(x_right, haz_a_lo, haz_a_hi)
                    || (pit_b_used && in_span(x_right, haz_b_lo, haz_b_hi));
    assign haz_left  = in_span(x_left, haz_a_lo, haz_a_hi)
                    || (pit_b_used && in_span(x_left, haz_b_lo, haz_b_hi));

    // below the floor the pit walls hold the character in
    assign below_floor = (char_y > `FLOOR_Y);
    assign step_right  = right && (x_right <= `WALK_LIMIT) && (door_depth == '0)
                      && (!below_floor || haz_right);
    assign step_left   = !right && left && (char_x >= `AREA_LEFT + `WALK_STEP)
                      && (door_depth == '0) && (!below_floor || haz_left);

    ////////////////////////////////////////////////////
    // gravity
    ////////////////////////////////////////////////////

    // positive speed moves up the screen
    assign dy      = {{(`COORD_W-SPEED_W){speed[SPEED_W-1]}}, speed};
    assign jump_dy = {{(`COORD_W-SPEED_W){1'b0}}, `JUMP_SPEED};
    assign spawn   = (level == LEVEL_START) || respawn || (char_y >= `FALL_LIMIT);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            char_x <= `SPAWN_X;
            char_y <= `FLOOR_Y;
            speed  <= '0;
            motion <= GROUNDED;
        end else if (spawn) begin
            char_x <= `SPAWN_X;
            char_y <= `FLOOR_Y;
            speed  <= '0;
            motion <= GROUNDED;
        end else begin
            if (step_right) begin
                char_x <= x_right;
            end else if (step_left) begin
                char_x <= x_left;
            end
            if (motion == GROUNDED && up) begin
                char_y <= char_y - jump_dy;
                speed  <= `JUMP_SPEED;
                motion <= haz_here ? IN_PIT : RISING_OR_FALLING;
            end else if (motion != GROUNDED || haz_here) begin
                if (!haz_here && char_y >= `FLOOR_Y) begin
                    char_y <= `FLOOR_Y;
                    speed  <= '0;
                    motion <= GROUNDED;
                end else begin
                    char_y <= char_y - dy;
                    if (step && speed != `MAX_FALL_SPEED) begin
                        speed <= speed - SPEED_W'(1);
                    end
                    motion <= haz_here ? IN_PIT : RISING_OR_FALLING;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/game_pkg.sv
`default_nettype none

package game_pkg;

    // level 0 is the title screen, left after one cycle
    typedef enum logic [1:0] {
        LEVEL_START,
        LEVEL_1,
        LEVEL_2,
        LEVEL_3
    } level_t;

    typedef enum logic [1:0] {
        GROUNDED,
        RISING_OR_FALLING,
        IN_PIT
    } motion_t;

endpackage

`default_nettype wire

//--- design/level_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

module level_sequencer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire  [`COORD_W-1:0]     char_x,
    input  wire  [`COORD_W-1:0]     pit_a_start,
    input  wire  [`COORD_W-1:0]     pit_b_start,
    input  wire                     pit_b_used,
    output game_pkg::level_t        level,
    output logic                    step,
    output logic                    respawn,
    output logic [`COORD_W-1:0]     door_depth,
    output logic                    blackout,
    output logic [`COORD_W-1:0]     pit_depth_a,
    output logic [`COORD_W-1:0]     pit_depth_b
);
    import game_pkg::*;

    logic [1:0] step_cnt;
    logic [5:0] blackout_cnt;
    logic       grow_a;
    logic       grow_b;
    logic       grow_door;
    level_t     next_level;

    assign step    = (step_cnt == 2'd0);
    // last blackout cycle, level swaps at its end
    assign respawn = (blackout_cnt == `BLACKOUT_CYCLES);

    assign grow_a = step && (char_x > pit_a_start - `PIT_TRIGGER)
                 && (pit_depth_a != `PIT_DEPTH_MAX);
    assign grow_b = step && pit_b_used && (char_x > pit_b_start - `PIT_TRIGGER)
                 && (pit_depth_b != `PIT_DEPTH_MAX);
    assign grow_door = step && (char_x > `DOOR_TRIGGER) && (door_depth != `DOOR_OPEN);

    always_comb begin
        case (level)
            LEVEL_1: next_level = LEVEL_2;
            LEVEL_2: next_level = LEVEL_3;
            default: next_level = LEVEL_1;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            level        <= LEVEL_START;
            step_cnt     <= 2'd0;
            door_depth   <= '0;
            blackout     <= 1'b0;
            blackout_cnt <= '0;
            pit_depth_a  <= '0;
            pit_depth_b  <= '0;
        end else begin
            step_cnt <= (step_cnt == `STEP_DIV - 2'd1) ? 2'd0 : step_cnt + 2'd1;
            if (level == LEVEL_START) begin
                level <= LEVEL_1;
            end else if (respawn) begin
                level        <= next_level;
                door_depth   <= '0;
                blackout     <= 1'b0;
                blackout_cnt <= '0;
                pit_depth_a  <= '0;
                pit_depth_b  <= '0;
            end else begin
                if (grow_a) begin
                    pit_depth_a <= pit_depth_a + `PIT_GROW;
                end
                if (grow_b) begin
                    pit_depth_b <= pit_depth_b + `PIT_GROW;
                end
                if (grow_door) begin
                    door_depth <= door_depth + `DOOR_STEP;
                end
                // door fully open, screen goes dark
                if (door_depth == `DOOR_OPEN) begin
                    blackout     <= 1'b1;
                    blackout_cnt <= blackout_cnt + 6'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/level_table.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

module level_table (
    input  wire game_pkg::level_t       level,
    output logic     [`COORD_W-1:0]     pit_a_start,
    output logic     [`COORD_W-1:0]     pit_a_end,
    output logic     [`COORD_W-1:0]     pit_b_start,
    output logic     [`COORD_W-1:0]     pit_b_end,
    output logic                        pit_b_used
);
    import game_pkg::*;

    // visual pit bounds, hit boxes are trimmed downstream
    always_comb begin
        pit_b_start = '0;
        pit_b_end   = '0;
        pit_b_used  = 1'b0;
        case (level)
            LEVEL_2: begin
                pit_a_start = 10'd450;
                pit_a_end   = 10'd500;
                pit_b_start = 10'd600;
                pit_b_end   = 10'd650;
                pit_b_used  = 1'b1;
            end
            LEVEL_3: begin
                pit_a_start = 10'd600;
                pit_a_end   = 10'd650;
            end
            // title screen shares the level 1 layout
            default: begin
                pit_a_start = 10'd500;
                pit_a_end   = 10'd550;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/platformer_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

module platformer_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     up,
    input  wire                     down,
    input  wire                     left,
    input  wire                     right,
    input  wire  [`COORD_W-1:0]     hcount,
    input  wire  [`COORD_W-1:0]     vcount,
    output logic [`RGB_W-1:0]       rgb,
    output game_pkg::level_t        level,
    output logic [`COORD_W-1:0]     char_x,
    output logic [`COORD_W-1:0]     char_y
);
    import game_pkg::*;

    logic                step;
    logic                respawn;
    logic                blackout;
    logic                pit_b_used;
    logic [`COORD_W-1:0] door_depth;
    logic [`COORD_W-1:0] pit_depth_a;
    logic [`COORD_W-1:0] pit_depth_b;
    logic [`COORD_W-1:0] pit_a_start;
    logic [`COORD_W-1:0] pit_a_end;
    logic [`COORD_W-1:0] pit_b_start;
    logic [`COORD_W-1:0] pit_b_end;
    motion_t             motion;

    level_sequencer u_level_sequencer (
        .clk         (clk),
        .reset       (reset),
        .char_x      (char_x),
        .pit_a_start (pit_a_start),
        .pit_b_start (pit_b_start),
        .pit_b_used  (pit_b_used),
        .level       (level),
        .step        (step),
        .respawn     (respawn),
        .door_depth  (door_depth),
        .blackout    (blackout),
        .pit_depth_a (pit_depth_a),
        .pit_depth_b (pit_depth_b)
    );

    level_table u_level_table (
        .level       (level),
        .pit_a_start (pit_a_start),
        .pit_a_end   (pit_a_end),
        .pit_b_start (pit_b_start),
        .pit_b_end   (pit_b_end),
        .pit_b_used  (pit_b_used)
    );

    // down has no function in this game
    character_motion u_character_motion (
        .clk         (clk),
        .reset       (reset),
        .up          (up),
        .left        (left),
        .right       (right),
        .level       (level),
        .step        (step),
        .respawn     (respawn),
        .door_depth  (door_depth),
        .pit_a_start (pit_a_start),
        .pit_a_end   (pit_a_end),
        .pit_b_start (pit_b_start),
        .pit_b_end   (pit_b_end),
        .pit_b_used  (pit_b_used),
        .char_x      (char_x),
        .char_y      (char_y),
        .motion      (motion)
    );

    scene_renderer u_scene_renderer (
        .hcount      (hcount),
        .vcount      (vcount),
        .level       (level),
        .char_x      (char_x),
        .char_y      (char_y),
        .door_depth  (door_depth),
        .blackout    (blackout),
        .pit_a_start (pit_a_start),
        .pit_a_end   (pit_a_end),
        .pit_b_start (pit_b_start),
        .pit_b_end   (pit_b_end),
        .pit_b_used  (pit_b_used),
        .pit_depth_a (pit_depth_a),
        .pit_depth_b (pit_depth_b),
        .rgb         (rgb)
    );

endmodule

`default_nettype wire

//--- design/scene_renderer.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

module scene_renderer (
    input  wire  [`COORD_W-1:0]     hcount,
    input  wire  [`COORD_W-1:0]     vcount,
    input  wire game_pkg::level_t   level,
    input  wire  [`COORD_W-1:0]     char_x,
    input  wire  [`COORD_W-1:0]     char_y,
    input  wire  [`COORD_W-1:0]     door_depth,
    input  wire                     blackout,
    input  wire  [`COORD_W-1:0]     pit_a_start,
    input  wire  [`COORD_W-1:0]     pit_a_end,
    input  wire  [`COORD_W-1:0]     pit_b_start,
    input  wire  [`COORD_W-1:0]     pit_b_end,
    input  wire                     pit_b_used,
    input  wire  [`COORD_W-1:0]     pit_depth_a,
    input  wire  [`COORD_W-1:0]     pit_depth_b,
    output logic [`RGB_W-1:0]       rgb
);
    import game_pkg::*;

    logic char_zone;
    logic door_zone;
    logic area_zone;
    logic pit_a_zone;
    logic pit_b_zone;

    // char_y is the row of the feet
    assign char_zone  = (hcount >= char_x) && (hcount <= char_x + `CHAR_W)
                     && (vcount >= char_y - `CHAR_H) && (vcount <= char_y);
    // door slides down as it opens
    assign door_zone  = (hcount >= `DOOR_LEFT) && (hcount <= `DOOR_RIGHT)
                     && (vcount >= `DOOR_TOP + door_depth) && (vcount <= `FLOOR_Y);
    assign area_zone  = (hcount >= `AREA_LEFT) && (hcount <= `AREA_RIGHT)
                     && (vcount >= `AREA_TOP) && (vcount <= `FLOOR_Y);
    assign pit_a_zone = (hcount >= pit_a_start) && (hcount <= pit_a_end)
                     && (vcount >= `FLOOR_Y) && (vcount <= `FLOOR_Y + pit_depth_a);
    assign pit_b_zone = pit_b_used && (hcount >= pit_b_start) && (hcount <= pit_b_end)
                     && (vcount >= `FLOOR_Y) && (vcount <= `FLOOR_Y + pit_depth_b);

    always_comb begin
        if (level == LEVEL_START) begin
            rgb = `COLOR_INK;
        end else if (char_zone) begin
            rgb = `COLOR_INK;
        end else if (door_zone && !blackout) begin
            rgb = `COLOR_DOOR;
        end else if (blackout) begin
            rgb = `COLOR_INK;
        end else if (area_zone) begin
            rgb = `COLOR_AREA;
        end else if (pit_a_zone || pit_b_zone) begin
            rgb = `COLOR_PIT;
        end else begin
            rgb = `COLOR_SKY;
        end
    end

endmodule

`default_nettype wire

//--- include/game_defines.svh
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// screen and play area, in pixels
`define COORD_W          10
`define RGB_W            12
`define FLOOR_Y          10'd350
`define AREA_LEFT        10'd250
`define AREA_RIGHT       10'd750
`define AREA_TOP         10'd200
`define WALK_LIMIT       10'd730
`define SPAWN_X          10'd300
`define FALL_LIMIT       10'd600
`define CHAR_W           10'd20
`define CHAR_H           10'd30

// motion, speed is 4 bit two's complement
`define WALK_STEP        10'd2
`define JUMP_SPEED       4'sd5
`define MAX_FALL_SPEED   (-4'sd5)
`define STEP_DIV         2'd3

// pits and their hit box trims
`define PIT_GROW         10'd20
`define PIT_DEPTH_MAX    10'd200
`define PIT_TRIGGER      10'd40
`define HIT_START_TRIM   10'd5
`define HIT_END_TRIM     10'd12

// door
`define DOOR_LEFT        10'd675
`define DOOR_RIGHT       10'd715
`define DOOR_TOP         10'd300
`define DOOR_TRIGGER     10'd670
`define DOOR_STEP        10'd5
`define DOOR_OPEN        10'd50
`define BLACKOUT_CYCLES  6'd50

// palette
`define COLOR_INK        12'hFFF
`define COLOR_AREA       12'hEA7
`define COLOR_SKY        12'h750
`define COLOR_PIT        12'h196
`define COLOR_DOOR       12'h9FA

`endif

//--- tests/platformer_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_defines.svh"

module platformer_tb;
    import game_pkg::*;

    localparam int CLK_PERIOD       = 100;
    localparam int JUMP_TIMEOUT     = 100;
    localparam int FALL_TIMEOUT     = 200;
    localparam int RESPAWN_TIMEOUT  = 400;
    localparam int DOOR_TIMEOUT     = 1000;
    localparam int BLACKOUT_TIMEOUT = 100;
    // several times the sum of the per-test timeouts
    localparam int WATCHDOG_CYCLES  = 20000;
    // a landing may end below the floor by less than one full fall step
    localparam int LANDING_SLACK    = 5;

    logic                clk;
    logic                reset;
    logic                up;
    logic                down;
    logic                left;
    logic                right;
    logic [`COORD_W-1:0] hcount;
    logic [`COORD_W-1:0] vcount;
    logic [`RGB_W-1:0]   rgb;
    level_t              level;
    logic [`COORD_W-1:0] char_x;
    logic [`COORD_W-1:0] char_y;

    platformer_top u_platformer_top (
        .clk    (clk),
        .reset  (reset),
        .up     (up),
        .down   (down),
        .left   (left),
        .right  (right),
        .hcount (hcount),
        .vcount (vcount),
        .rgb    (rgb),
        .level  (level),
        .char_x (char_x),
        .char_y (char_y)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Something failed");
        $fatal(1);
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic check_equal(input string name, input int actual, input int expected);
        assert (actual == expected) else begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("at %0t ns: %s", $time, what);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_spawn_position();
        check_equal("char_x", int'(char_x), int'(`SPAWN_X));
        check_equal("char_y", int'(char_y), int'(`FLOOR_Y));
    endtask

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
    endtask

    // rgb settles right after the scan position changes
    task automatic sample_pixel(input int x, input int y, output int color);
        hcount = `COORD_W'(x);
        vcount = `COORD_W'(y);
        #1;
        color = int'(rgb);
    endtask

    task automatic walk(input logic go_right, input int cycles);
        int expected_x;
        expected_x = int'(char_x);
        right = go_right;
        left  = !go_right;
        repeat (cycles) begin
            @(negedge clk);
            if (go_right) begin
                expected_x = expected_x + int'(`WALK_STEP);
            end else begin
                expected_x = expected_x - int'(`WALK_STEP);
            end
            check_equal("char_x", int'(char_x), expected_x);
        end
        right = 1'b0;
        left  = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic test_reset_and_start();
        int color;
        apply_reset();
        @(negedge clk);
        check_equal("level", int'(level), int'(LEVEL_1));
        check_spawn_position();
        sample_pixel(100, 100, color);
        check_equal("rgb at 100,100", color, int'(`COLOR_SKY));
        sample_pixel(400, 250, color);
        check_equal("rgb at 400,250", color, int'(`COLOR_AREA));
        sample_pixel(305, 340, color);
        check_equal("rgb at 305,340", color, int'(`COLOR_INK));
        @(negedge clk);
    endtask

    task automatic test_walking();
        int right_cycles;
        int left_cycles;
        right_cycles = 1 + int'($urandom % 32'd40);
        left_cycles  = 1 + int'($urandom % right_cycles);
        walk(1'b1, right_cycles);
        walk(1'b0, left_cycles);
        // far more cycles than the way back to the left edge
        left = 1'b1;
        repeat (100) begin
            @(negedge clk);
            check_true(int'(char_x) >= int'(`AREA_LEFT),
                       "character walked past the left edge of the play area");
        end
        left = 1'b0;
        check_true(int'(char_x) <= int'(`AREA_LEFT) + 1,
                   "character stopped short of the left edge of the play area");
        walk(1'b1, (int'(`SPAWN_X) - int'(char_x)) / int'(`WALK_STEP));
        check_spawn_position();
    endtask

    task automatic test_jump();
        int waited;
        up = 1'b1;
        @(negedge clk);
        up = 1'b0;
        check_equal("char_y", int'(char_y), int'(`FLOOR_Y) - int'(`JUMP_SPEED));
        waited = 0;
        while (int'(char_y) != int'(`FLOOR_Y)) begin
            check_true(waited < JUMP_TIMEOUT, "jump did not land within 100 cycles");
            check_true(int'(char_y) >= int'(`FLOOR_Y) - 60,
                       "jump rose more than 60 pixels above the floor");
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
        check_spawn_position();
    endtask

    task automatic test_pit_fall();
        int   waited;
        logic pit_seen;
        check_spawn_position();
        hcount   = 10'd520;
        vcount   = 10'd360;
        right    = 1'b1;
        pit_seen = 1'b0;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
            check_true(waited < FALL_TIMEOUT, "character never fell into the level 1 pit");
            if (int'(char_y) == int'(`FLOOR_Y) && int'(rgb) == int'(`COLOR_PIT)) begin
                pit_seen = 1'b1;
            end
        end while (int'(char_y) == int'(`FLOOR_Y));
        right = 1'b0;
        check_true(int'(char_y) > int'(`FLOOR_Y), "character rose instead of falling");
        check_true(int'(char_x) > 495, "character fell before reaching the pit");
        check_true(pit_seen, "pit at 520,360 was not drawn before the fall");
        waited = 0;
        while (!(int'(char_x) == int'(`SPAWN_X) && int'(char_y) == int'(`FLOOR_Y))) begin
            check_true(waited < RESPAWN_TIMEOUT, "character did not respawn after the fall");
            @(negedge clk);
            waited++;
        end
    endtask

    // second_jump of 0 means the level has a single pit
    task automatic cross_level(input int first_jump, input int second_jump,
                               input level_t next_level);
        level_t start_level;
        int     waited;
        start_level = level;
        check_spawn_position();
        hcount = 10'd400;
        vcount = 10'd250;
        right  = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            up = (int'(char_x) == first_jump) || (int'(char_x) == second_jump);
            check_true(waited < DOOR_TIMEOUT, "the door did not open into a blackout");
            check_true(int'(char_y) < int'(`FLOOR_Y) + LANDING_SLACK,
                       "character fell into a pit on the way to the door");
        end while (int'(rgb) != int'(`COLOR_INK));
        right  = 1'b0;
        up     = 1'b0;
        waited = 0;
        while (level == start_level) begin
            check_equal("rgb at 400,250 in blackout", int'(rgb), int'(`COLOR_INK));
            check_true(waited < BLACKOUT_TIMEOUT, "level did not advance after the blackout");
            @(negedge clk);
            waited++;
        end
        check_equal("level", int'(level), int'(next_level));
        check_spawn_position();
    endtask

    task automatic test_door_and_levels();
        cross_level(480, 0, LEVEL_2);
        cross_level(450 - 20, 600 - 20, LEVEL_3);
        cross_level(600 - 20, 0, LEVEL_1);
    endtask

    initial begin
        void'($urandom(32'h42a3975e));
        reset  = 1'b1;
        up     = 1'b0;
        down   = 1'b0;
        left   = 1'b0;
        right  = 1'b0;
        hcount = '0;
        vcount = '0;
        test_reset_and_start();
        test_walking();
        test_jump();
        test_pit_fall();
        test_door_and_levels();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
